//--- files.f
+incdir+include
design/ooo_pkg.sv
design/register_file.sv
design/reorder_buffer.sv
design/dispatch_unit.sv
design/rename_core.sv
test/rename_core_tb.sv

//--- test/rename_core_tb.sv
`include "ooo_consts.svh"

module rename_core_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import ooo_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int FILL_INSTR   = 2 * `ROB_DEPTH;
	localparam int RANDOM_INSTR = 200;
	// reset test 3, write after write test 6
	localparam int TOTAL_INSTR  = 3 + FILL_INSTR + 6 + RANDOM_INSTR;

	logic       clk;
	logic       reset;
	logic       dispatch_valid;
	reg_index_t dispatch_rs1;
	reg_index_t dispatch_rs2;
	reg_index_t dispatch_rd;
	logic       dispatch_has_rd;
	logic       complete_valid;
	rob_tag_t   complete_tag;
	word_t      complete_value;
	logic       credit_return;
	logic       issue_valid;
	rob_tag_t   issue_tag;
	logic       issue_src1_ready;
	logic       issue_src2_ready;
	word_t      issue_src1_value;
	word_t      issue_src2_value;
	rob_tag_t   issue_src1_tag;
	rob_tag_t   issue_src2_tag;
	logic       retire_valid;
	reg_index_t retire_rd;
	word_t      retire_value;
	rob_tag_t   retire_tag;

	// shadow architectural file and rename table
	word_t      arch [`NUM_REGS];
	logic       ren_valid [`NUM_REGS];
	rob_tag_t   ren_tag [`NUM_REGS];
	// shadow ROB entries, indexed by tag
	logic       e_busy [`ROB_DEPTH];
	logic       e_done [`ROB_DEPTH];
	word_t      e_value [`ROB_DEPTH];
	reg_index_t e_rd [`ROB_DEPTH];
	logic       e_has_rd [`ROB_DEPTH];
	// tags in dispatch order, oldest first
	rob_tag_t   inflight [$];
	rob_tag_t   m_tail;
	int         credits;
	int         dispatched;
	int         retired_count = 0;
	int         fail_count = 0;
	int         test_count = 0;

	// issue expectations, computed at dispatch and moved to exp_* one cycle later
	logic       nxt_valid;
	logic       nxt_r1;
	logic       nxt_r2;
	rob_tag_t   nxt_tag;
	rob_tag_t   nxt_t1;
	rob_tag_t   nxt_t2;
	word_t      nxt_v1;
	word_t      nxt_v2;
	logic       exp_issue_valid;
	logic       exp_src1_ready;
	logic       exp_src2_ready;
	rob_tag_t   exp_issue_tag;
	rob_tag_t   exp_src1_tag;
	rob_tag_t   exp_src2_tag;
	word_t      exp_src1_value;
	word_t      exp_src2_value;
	// retire expectations for the current cycle
	logic       exp_retire_valid;
	rob_tag_t   exp_retire_tag;
	reg_index_t exp_retire_rd;
	word_t      exp_retire_value;

	rename_core dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// retirements seen on the DUT outputs
	always @(posedge clk) begin
		if (reset && retire_valid) begin
			retired_count <= retired_count + 1;
		end
	end

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("MISMATCH %s expected %h actual %h", name, expected, actual);
		fail_count++;
	endtask

	assert property (@(posedge clk) disable iff (!reset) issue_valid == exp_issue_valid)
		else report_mismatch("issue_valid", $sampled(exp_issue_valid), $sampled(issue_valid));
	assert property (@(posedge clk) disable iff (!reset)
		exp_issue_valid |-> issue_tag == exp_issue_tag)
		else report_mismatch("issue_tag", $sampled(exp_issue_tag), $sampled(issue_tag));
	assert property (@(posedge clk) disable iff (!reset)
		exp_issue_valid |-> issue_src1_ready == exp_src1_ready)
		else report_mismatch("issue_src1_ready", $sampled(exp_src1_ready),
			$sampled(issue_src1_ready));
	assert property (@(posedge clk) disable iff (!reset)
		exp_issue_valid && exp_src1_ready |-> issue_src1_value == exp_src1_value)
		else report_mismatch("issue_src1_value", $sampled(exp_src1_value),
			$sampled(issue_src1_value));
	// the tag only means something while the source waits
	assert property (@(posedge clk) disable iff (!reset)
		exp_issue_valid && !exp_src1_ready |-> issue_src1_tag == exp_src1_tag)
		else report_mismatch("issue_src1_tag", $sampled(exp_src1_tag),
			$sampled(issue_src1_tag));
	assert property (@(posedge clk) disable iff (!reset)
		exp_issue_valid |-> issue_src2_ready == exp_src2_ready)
		else report_mismatch("issue_src2_ready", $sampled(exp_src2_ready),
			$sampled(issue_src2_ready));
	assert property (@(posedge clk) disable iff (!reset)
		exp_issue_valid && exp_src2_ready |-> issue_src2_value == exp_src2_value)
		else report_mismatch("issue_src2_value", $sampled(exp_src2_value),
			$sampled(issue_src2_value));
	assert property (@(posedge clk) disable iff (!reset)
		exp_issue_valid && !exp_src2_ready |-> issue_src2_tag == exp_src2_tag)
		else report_mismatch("issue_src2_tag", $sampled(exp_src2_tag),
			$sampled(issue_src2_tag));
	assert property (@(posedge clk) disable iff (!reset) retire_valid == exp_retire_valid)
		else report_mismatch("retire_valid", $sampled(exp_retire_valid),
			$sampled(retire_valid));
	// exactly one credit per retirement
	assert property (@(posedge clk) disable iff (!reset) credit_return == exp_retire_valid)
		else report_mismatch("credit_return", $sampled(exp_retire_valid),
			$sampled(credit_return));
	assert property (@(posedge clk) disable iff (!reset)
		exp_retire_valid |-> retire_tag == exp_retire_tag)
		else report_mismatch("retire_tag", $sampled(exp_retire_tag), $sampled(retire_tag));
	assert property (@(posedge clk) disable iff (!reset)
		exp_retire_valid |-> retire_rd == exp_retire_rd)
		else report_mismatch("retire_rd", $sampled(exp_retire_rd), $sampled(retire_rd));
	assert property (@(posedge clk) disable iff (!reset)
		exp_retire_valid |-> retire_value == exp_retire_value)
		else report_mismatch("retire_value", $sampled(exp_retire_value),
			$sampled(retire_value));

	// expected operand for one source
	// a completion in the same cycle already counts
	function automatic void resolve(input reg_index_t r, input logic c_acc, input rob_tag_t ct,
			input word_t cval, output logic rdy, output word_t val, output rob_tag_t tag);
		rdy = 1'b1;
		val = '0;
		tag = '0;
		if (r != '0) begin
			if (!ren_valid[r]) begin
				val = arch[r];
			end else begin
				tag = ren_tag[r];
				if (c_acc && ct == tag) begin
					val = cval;
				end else if (e_done[tag]) begin
					val = e_value[tag];
				end else begin
					rdy = 1'b0;
				end
			end
		end
	endfunction

	// one clock cycle of stimulus, plus the model step for it
	task automatic run_cycle(input logic dv, input reg_index_t s1, input reg_index_t s2,
			input reg_index_t d, input logic hd, input logic cv, input rob_tag_t ct,
			input word_t cval);
		logic     retiring;
		logic     c_acc;
		rob_tag_t h;
		@(posedge clk);
		exp_issue_valid <= nxt_valid;
		exp_issue_tag   <= nxt_tag;
		exp_src1_ready  <= nxt_r1;
		exp_src1_value  <= nxt_v1;
		exp_src1_tag    <= nxt_t1;
		exp_src2_ready  <= nxt_r2;
		exp_src2_value  <= nxt_v2;
		exp_src2_tag    <= nxt_t2;
		// oldest entry retires once its result is in
		h        = (inflight.size() > 0) ? inflight[0] : '0;
		retiring = (inflight.size() > 0) && e_done[h];
		exp_retire_valid <= retiring;
		exp_retire_tag   <= h;
		exp_retire_rd    <= e_rd[h];
		exp_retire_value <= e_value[h];
		dispatch_valid  <= dv;
		dispatch_rs1    <= s1;
		dispatch_rs2    <= s2;
		dispatch_rd     <= d;
		dispatch_has_rd <= hd;
		complete_valid  <= cv;
		complete_tag    <= ct;
		complete_value  <= cval;
		// results for free or finished entries are dropped
		c_acc     = cv && e_busy[ct] && !e_done[ct];
		nxt_valid = dv;
		if (dv) begin
			nxt_tag = m_tail;
			resolve(s1, c_acc, ct, cval, nxt_r1, nxt_v1, nxt_t1);
			resolve(s2, c_acc, ct, cval, nxt_r2, nxt_v2, nxt_t2);
		end
		// model state after the edge that ends this cycle
		if (c_acc) begin
			e_done[ct]  = 1'b1;
			e_value[ct] = cval;
		end
		if (retiring) begin
			if (e_has_rd[h] && e_rd[h] != '0) begin
				arch[e_rd[h]] = e_value[h];
				// a younger writer keeps its tag
				if (ren_valid[e_rd[h]] && ren_tag[e_rd[h]] == h) begin
					ren_valid[e_rd[h]] = 1'b0;
				end
			end
			e_busy[h] = 1'b0;
			e_done[h] = 1'b0;
			void'(inflight.pop_front());
			credits++;
		end
		if (dv) begin
			e_busy[m_tail]   = 1'b1;
			e_done[m_tail]   = 1'b0;
			e_rd[m_tail]     = d;
			e_has_rd[m_tail] = hd;
			// rename after the retire clear, so it wins on the same register
			if (hd && d != '0) begin
				ren_valid[d] = 1'b1;
				ren_tag[d]   = m_tail;
			end
			inflight.push_back(m_tail);
			m_tail++;
			credits--;
			dispatched++;
		end
	endtask

	// random result for a waiting entry about every other cycle
	// now and then a result for any tag, which the ROB drops unless that entry still waits
	task automatic pick_completion(output logic cv, output rob_tag_t ct, output word_t cval);
		rob_tag_t cand [$];
		cv   = 1'b0;
		ct   = '0;
		cval = $urandom();
		foreach (inflight[i]) begin
			if (!e_done[inflight[i]]) begin
				cand.push_back(inflight[i]);
			end
		end
		if (cand.size() > 0 && $urandom_range(1, 0) == 1) begin
			cv = 1'b1;
			ct = cand[$urandom_range(cand.size() - 1, 0)];
		end else if ($urandom_range(7, 0) == 0) begin
			cv = 1'b1;
			ct = $urandom_range(`ROB_DEPTH - 1, 0);
		end
	endtask

	task automatic idle_cycle();
		run_cycle(1'b0, '0, '0, '0, 1'b0, 1'b0, '0, '0);
	endtask

	task automatic drain();
		logic     cv;
		rob_tag_t ct;
		word_t    cval;
		while (inflight.size() > 0) begin
			pick_completion(cv, ct, cval);
			run_cycle(1'b0, '0, '0, '0, 1'b0, cv, ct, cval);
		end
		// last retire and issue are sampled on these edges
		idle_cycle();
		idle_cycle();
	endtask

	task automatic finish_test(input string name);
		test_count++;
		assert (retired_count == dispatched) else begin
			$display("%s: %0d instructions dispatched but %0d retired", name, dispatched,
				retired_count);
			fail_count++;
		end
		$display("test %s finished, %0d dispatched, %0d errors so far", name, dispatched,
			fail_count);
	endtask

	task automatic check_reset_state();
		@(negedge clk);
		assert (!issue_valid && !retire_valid && !credit_return) else begin
			$display("control outputs are not low after reset");
			fail_count++;
		end
		// independent sources, all zero with no tags
		run_cycle(1'b1, 5'd1, 5'd2, 5'd3, 1'b1, 1'b0, '0, '0);
		run_cycle(1'b1, 5'd4, 5'd5, 5'd6, 1'b1, 1'b0, '0, '0);
		run_cycle(1'b1, 5'd7, 5'd0, 5'd8, 1'b1, 1'b0, '0, '0);
		drain();
		finish_test("reset_state");
	endtask

	// fill_first holds results back until the ROB is full
	task automatic run_random(input int count, input logic fill_first, input string name);
		int       n;
		logic     dv;
		logic     cv;
		rob_tag_t ct;
		word_t    cval;
		n = 0;
		while (n < count) begin
			dv = (credits > 0) && (fill_first || $urandom_range(3, 0) != 0);
			pick_completion(cv, ct, cval);
			if (fill_first && n < `ROB_DEPTH) begin
				cv = 1'b0;
			end
			// few registers, so sources often hit in-flight writers
			run_cycle(dv, $urandom_range(7, 0), $urandom_range(7, 0), $urandom_range(7, 0),
				$urandom_range(3, 0) != 0, cv, ct, cval);
			if (dv) begin
				n++;
			end
		end
		drain();
		finish_test(name);
	endtask

	task automatic check_write_after_write();
		rob_tag_t older;
		rob_tag_t younger;
		older = m_tail;
		run_cycle(1'b1, 5'd1, 5'd2, 5'd5, 1'b1, 1'b0, '0, '0);
		younger = m_tail;
		run_cycle(1'b1, 5'd3, 5'd4, 5'd5, 1'b1, 1'b0, '0, '0);
		// waits on the younger writer
		run_cycle(1'b1, 5'd5, 5'd0, 5'd6, 1'b1, 1'b0, '0, '0);
		run_cycle(1'b0, '0, '0, '0, 1'b0, 1'b1, older, $urandom());
		// older writer retires here and must not clear the younger tag
		idle_cycle();
		run_cycle(1'b1, 5'd5, 5'd5, 5'd7, 1'b1, 1'b0, '0, '0);
		// younger result arrives in the reader's own dispatch cycle
		run_cycle(1'b1, 5'd5, 5'd0, 5'd8, 1'b1, 1'b1, younger, $urandom());
		drain();
		// both writers gone, architectural value only
		run_cycle(1'b1, 5'd5, 5'd5, 5'd0, 1'b0, 1'b0, '0, '0);
		drain();
		finish_test("write_after_write");
	endtask

	initial begin
		void'($urandom(32617));
		for (int i = 0; i < `NUM_REGS; i++) begin
			arch[i]      = '0;
			ren_valid[i] = 1'b0;
			ren_tag[i]   = '0;
		end
		for (int i = 0; i < `ROB_DEPTH; i++) begin
			e_busy[i]   = 1'b0;
			e_done[i]   = 1'b0;
			e_value[i]  = '0;
			e_rd[i]     = '0;
			e_has_rd[i] = 1'b0;
		end
		m_tail           = '0;
		credits          = `ROB_DEPTH;
		dispatched       = 0;
		nxt_valid        = 1'b0;
		exp_issue_valid  = 1'b0;
		exp_retire_valid = 1'b0;
		reset            = 1'b0;
		dispatch_valid   = 1'b0;
		dispatch_rs1     = '0;
		dispatch_rs2     = '0;
		dispatch_rd      = '0;
		dispatch_has_rd  = 1'b0;
		complete_valid   = 1'b0;
		complete_tag     = '0;
		complete_value   = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b1;
		check_reset_state();
		run_random(FILL_INSTR, 1'b1, "fill_drain");
		check_write_after_write();
		run_random(RANDOM_INSTR, 1'b0, "random");
		$display("tests %0d, instructions %0d, retired %0d, errors %0d", test_count,
			dispatched, retired_count, fail_count);
		if (fail_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// generous bound per instruction plus the reset time
	initial begin
		#((RESET_CYCLES + 40 * TOTAL_INSTR) * 10);
		$display("watchdog expired before all tests finished");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- design/rename_core.sv
`include "ooo_consts.svh"

module rename_core (
	input  logic                clk,
	input  logic                reset,

	// dispatch from the decoder
	input  logic                dispatch_valid,
	input  ooo_pkg::reg_index_t dispatch_rs1,
	input  ooo_pkg::reg_index_t dispatch_rs2,
	input  ooo_pkg::reg_index_t dispatch_rd,
	input  logic                dispatch_has_rd,

	// results from the execution units
	input  logic                complete_valid,
	input  ooo_pkg::rob_tag_t   complete_tag,
	input  ooo_pkg::word_t      complete_value,

	// one credit back per retirement
	output logic                credit_return,

	// issue group
	output logic                issue_valid,
	output ooo_pkg::rob_tag_t   issue_tag,
	output logic                issue_src1_ready,
	output logic                issue_src2_ready,
	output ooo_pkg::word_t      issue_src1_value,
	output ooo_pkg::word_t      issue_src2_value,
	output ooo_pkg::rob_tag_t   issue_src1_tag,
	output ooo_pkg::rob_tag_t   issue_src2_tag,

	// retire group
	output logic                retire_valid,
	output ooo_pkg::reg_index_t retire_rd,
	output ooo_pkg::word_t      retire_value,
	output ooo_pkg::rob_tag_t   retire_tag
);

	import ooo_pkg::*;

	// register file reads
	reg_index_t rs1_index;
	reg_index_t rs2_index;
	word_t      rs1;
	word_t      rs2;
	rob_tag_t   rs1_rob_tag;
	rob_tag_t   rs2_rob_tag;
	logic       rs1_rob_tag_valid;
	logic       rs2_rob_tag_valid;

	// rename port
	logic       rename_en;
	reg_index_t rename_index;
	rob_tag_t   rename_tag;

	// ROB allocation and lookups
	logic       alloc_en;
	reg_index_t alloc_rd;
	logic       alloc_has_rd;
	rob_tag_t   alloc_tag;
	rob_tag_t   lookup1_tag;
	rob_tag_t   lookup2_tag;
	logic       lookup1_done;
	logic       lookup2_done;
	word_t      lookup1_value;
	word_t      lookup2_value;

	// retire write, which the ROB also drives out as the retire group
	logic       write_en;

	register_file register_file_i (
		.clk               (clk),
		.reset             (reset),
		.rs1_index         (rs1_index),
		.rs2_index         (rs2_index),
		.rd_index          (retire_rd),
		.rd                (retire_value),
		.rd_rob_index      (retire_tag),
		.write_en          (write_en),
		.rename_en         (rename_en),
		.rename_index      (rename_index),
		.rename_tag        (rename_tag),
		.rs1               (rs1),
		.rs1_rob_tag       (rs1_rob_tag),
		.rs1_rob_tag_valid (rs1_rob_tag_valid),
		.rs2               (rs2),
		.rs2_rob_tag       (rs2_rob_tag),
		.rs2_rob_tag_valid (rs2_rob_tag_valid)
	);

	reorder_buffer reorder_buffer_i (
		.clk            (clk),
		.reset          (reset),
		.alloc_en       (alloc_en),
		.alloc_rd       (alloc_rd),
		.alloc_has_rd   (alloc_has_rd),
		.alloc_tag      (alloc_tag),
		.complete_valid (complete_valid),
		.complete_tag   (complete_tag),
		.complete_value (complete_value),
		.lookup1_tag    (lookup1_tag),
		.lookup2_tag    (lookup2_tag),
		.lookup1_done   (lookup1_done),
		.lookup2_done   (lookup2_done),
		.lookup1_value  (lookup1_value),
		.lookup2_value  (lookup2_value),
		.write_en       (write_en),
		.rd_index       (retire_rd),
		.rd             (retire_value),
		.rd_rob_index   (retire_tag),
		.retire_valid   (retire_valid),
		.credit_return  (credit_return)
	);

	dispatch_unit dispatch_unit_i (
		.clk               (clk),
		.reset             (reset),
		.dispatch_valid    (dispatch_valid),
		.dispatch_rs1      (dispatch_rs1),
		.dispatch_rs2      (dispatch_rs2),
		.dispatch_rd       (dispatch_rd),
		.dispatch_has_rd   (dispatch_has_rd),
		.rs1_index         (rs1_index),
		.rs2_index         (rs2_index),
		.rs1               (rs1),
		.rs1_rob_tag       (rs1_rob_tag),
		.rs1_rob_tag_valid (rs1_rob_tag_valid),
		.rs2               (rs2),
		.rs2_rob_tag       (rs2_rob_tag),
		.rs2_rob_tag_valid (rs2_rob_tag_valid),
		.rename_en         (rename_en),
		.rename_index      (rename_index),
		.rename_tag        (rename_tag),
		.alloc_en          (alloc_en),
		.alloc_rd          (alloc_rd),
		.alloc_has_rd      (alloc_has_rd),
		.alloc_tag         (alloc_tag),
		.lookup1_tag       (lookup1_tag),
		.lookup2_tag       (lookup2_tag),
		.lookup1_done      (lookup1_done),
		.lookup2_done      (lookup2_done),
		.lookup1_value     (lookup1_value),
		.lookup2_value     (lookup2_value),
		.issue_valid       (issue_valid),
		.issue_tag         (issue_tag),
		.issue_src1_ready  (issue_src1_ready),
		.issue_src2_ready  (issue_src2_ready),
		.issue_src1_value  (issue_src1_value),
		.issue_src2_value  (issue_src2_value),
		.issue_src1_tag    (issue_src1_tag),
		.issue_src2_tag    (issue_src2_tag)
	);

endmodule

//--- design/dispatch_unit.sv
`include "ooo_consts.svh"

module dispatch_unit (
	input  logic                clk,
	input  logic                reset,

	// decoded instruction from upstream
	input  logic                dispatch_valid,
	input  ooo_pkg::reg_index_t dispatch_rs1,
	input  ooo_pkg::reg_index_t dispatch_rs2,
	input  ooo_pkg::reg_index_t dispatch_rd,
	input  logic                dispatch_has_rd,

	// register file reads
	output ooo_pkg::reg_index_t rs1_index,
	output ooo_pkg::reg_index_t rs2_index,
	input  ooo_pkg::word_t      rs1,
	input  ooo_pkg::rob_tag_t   rs1_rob_tag,
	input  logic                rs1_rob_tag_valid,
	input  ooo_pkg::word_t      rs2,
	input  ooo_pkg::rob_tag_t   rs2_rob_tag,
	input  logic                rs2_rob_tag_valid,

	// register file rename
	output logic                rename_en,
	output ooo_pkg::reg_index_t rename_index,
	output ooo_pkg::rob_tag_t   rename_tag,

	// ROB allocation and lookups
	output logic                alloc_en,
	output ooo_pkg::reg_index_t alloc_rd,
	output logic                alloc_has_rd,
	input  ooo_pkg::rob_tag_t   alloc_tag,
	output ooo_pkg::rob_tag_t   lookup1_tag,
	output ooo_pkg::rob_tag_t   lookup2_tag,
	input  logic                lookup1_done,
	input  logic                lookup2_done,
	input  ooo_pkg::word_t      lookup1_value,
	input  ooo_pkg::word_t      lookup2_value,

	// issue group, one cycle after dispatch
	output logic                issue_valid,
	output ooo_pkg::rob_tag_t   issue_tag,
	output logic                issue_src1_ready,
	output logic                issue_src2_ready,
	output ooo_pkg::word_t      issue_src1_value,
	output ooo_pkg::word_t      issue_src2_value,
	output ooo_pkg::rob_tag_t   issue_src1_tag,
	output ooo_pkg::rob_tag_t   issue_src2_tag
);

	import ooo_pkg::*;

	logic  src1_ready;
	logic  src2_ready;
	word_t src1_value;
	word_t src2_value;

	assign rs1_index = dispatch_rs1;
	assign rs2_index = dispatch_rs2;

	// look up whichever producer the register file names
	assign lookup1_tag = rs1_rob_tag;
	assign lookup2_tag = rs2_rob_tag;

	// no pending writer means the register value is current
	// otherwise forward from the ROB once the producer is done
	assign src1_ready = !rs1_rob_tag_valid || lookup1_done;
	assign src2_ready = !rs2_rob_tag_valid || lookup2_done;
	assign src1_value = rs1_rob_tag_valid ? lookup1_value : rs1;
	assign src2_value = rs2_rob_tag_valid ? lookup2_value : rs2;

	// every dispatch takes the tail entry
	assign alloc_en     = dispatch_valid;
	assign alloc_rd     = dispatch_rd;
	assign alloc_has_rd = dispatch_has_rd;

	// register 0 is never renamed
	assign rename_en    = dispatch_valid && dispatch_has_rd && (dispatch_rd != '0);
	assign rename_index = dispatch_rd;
	assign rename_tag   = alloc_tag;

	always_ff @(posedge clk) begin
		if (!reset) begin
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= dispatch_valid;
		end
	end

	// issue payload, held between dispatches
	always_ff @(posedge clk) begin
		if (dispatch_valid) begin
			issue_tag        <= alloc_tag;
			issue_src1_ready <= src1_ready;
			issue_src2_ready <= src2_ready;
			issue_src1_value <= src1_value;
			issue_src2_value <= src2_value;
			issue_src1_tag   <= rs1_rob_tag;
			issue_src2_tag   <= rs2_rob_tag;
		end
	end

endmodule

//--- design/reorder_buffer.sv
`include "ooo_consts.svh"

module reorder_buffer (
	input  logic                clk,
	input  logic                reset,

	// allocation at the tail
	input  logic                alloc_en,
	input  ooo_pkg::reg_index_t alloc_rd,
	input  logic                alloc_has_rd,
	output ooo_pkg::rob_tag_t   alloc_tag,

	// results from the execution units
	input  logic                complete_valid,
	input  ooo_pkg::rob_tag_t   complete_tag,
	input  ooo_pkg::word_t      complete_value,

	// operand lookups for dispatch
	input  ooo_pkg::rob_tag_t   lookup1_tag,
	input  ooo_pkg::rob_tag_t   lookup2_tag,
	output logic                lookup1_done,
	output logic                lookup2_done,
	output ooo_pkg::word_t      lookup1_value,
	output ooo_pkg::word_t      lookup2_value,

	// retire port to the register file
	output logic                write_en,
	output ooo_pkg::reg_index_t rd_index,
	output ooo_pkg::word_t      rd,
	output ooo_pkg::rob_tag_t   rd_rob_index,
	output logic                retire_valid,
	output logic                credit_return
);

	import ooo_pkg::*;

	// oldest in-flight entry
	rob_tag_t head;
	// next entry to hand out
	rob_tag_t tail;

	// per entry control
	logic [`ROB_DEPTH-1:0] busy;
	logic [`ROB_DEPTH-1:0] done;

	// per entry payload
	reg_index_t            dest [`ROB_DEPTH];
	logic [`ROB_DEPTH-1:0] has_rd;
	word_t                 value [`ROB_DEPTH];

	logic complete_accept;
	logic lookup1_bypass;
	logic lookup2_bypass;

	assign alloc_tag = tail;

	// stray completions are dropped
	// this covers a free entry and a second result for the same tag
	assign complete_accept = complete_valid && busy[complete_tag] && !done[complete_tag];

	// retire when the oldest entry has its result
	assign retire_valid  = busy[head] && done[head];
	assign credit_return = retire_valid;

	// no write for an instruction without a destination
	assign write_en     = retire_valid && has_rd[head];
	assign rd_index     = dest[head];
	assign rd           = value[head];
	assign rd_rob_index = head;

	// a completion in this cycle is visible to a dispatch in the same cycle
	assign lookup1_bypass = complete_accept && (complete_tag == lookup1_tag);
	assign lookup2_bypass = complete_accept && (complete_tag == lookup2_tag);

	assign lookup1_done  = done[lookup1_tag] || lookup1_bypass;
	assign lookup2_done  = done[lookup2_tag] || lookup2_bypass;
	assign lookup1_value = lookup1_bypass ? complete_value : value[lookup1_tag];
	assign lookup2_value = lookup2_bypass ? complete_value : value[lookup2_tag];

	// pointers and entry state
	always_ff @(posedge clk) begin
		if (!reset) begin
			head <= '0;
			tail <= '0;
			busy <= '0;
			done <= '0;
		end else begin
			if (complete_accept) begin
				done[complete_tag] <= 1'b1;
			end
			if (retire_valid) begin
				busy[head] <= 1'b0;
				done[head] <= 1'b0;
				head       <= head + 1'b1;
			end
			// the credit scheme keeps tail off a live entry
			if (alloc_en) begin
				busy[tail] <= 1'b1;
				done[tail] <= 1'b0;
				tail       <= tail + 1'b1;
			end
		end
	end

	// entry payload
	// only meaningful while the entry is busy
	always_ff @(posedge clk) begin
		if (alloc_en) begin
			dest[tail]   <= alloc_rd;
			has_rd[tail] <= alloc_has_rd;
		end
		if (complete_accept) begin
			value[complete_tag] <= complete_value;
		end
	end

endmodule

//--- design/register_file.sv
`include "ooo_consts.svh"

module register_file (
	input  logic                clk,
	input  logic                reset,

	// read indices
	input  ooo_pkg::reg_index_t rs1_index,
	input  ooo_pkg::reg_index_t rs2_index,

	// retire write from the ROB head
	input  ooo_pkg::reg_index_t rd_index,
	input  ooo_pkg::word_t      rd,
	input  ooo_pkg::rob_tag_t   rd_rob_index,
	input  logic                write_en,

	// rename from dispatch
	input  logic                rename_en,
	input  ooo_pkg::reg_index_t rename_index,
	input  ooo_pkg::rob_tag_t   rename_tag,

	// read results
	output ooo_pkg::word_t      rs1,
	output ooo_pkg::rob_tag_t   rs1_rob_tag,
	output logic                rs1_rob_tag_valid,
	output ooo_pkg::word_t      rs2,
	output ooo_pkg::rob_tag_t   rs2_rob_tag,
	output logic                rs2_rob_tag_valid
);

	import ooo_pkg::*;

	// committed values
	word_t                regs [`NUM_REGS];
	// tag of the youngest in-flight writer of each register
	rob_tag_t             tags [`NUM_REGS];
	// tag 0 is a real entry, so a separate valid bit says whether a writer is pending
	logic [`NUM_REGS-1:0] tag_valid;

	logic retire_write;
	logic retire_clear;
	logic rename_write;

	// register 0 never takes a write or a tag
	assign retire_write = write_en && (rd_index != '0);
	assign rename_write = rename_en && (rename_index != '0);

	// drop the tag only when the retiring entry is still the youngest writer
	// a mismatch means a younger instruction renamed rd meanwhile
	assign retire_clear = retire_write && tag_valid[rd_index] &&
		(tags[rd_index] == rd_rob_index);

	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
				tags[i] <= '0;
			end
			tag_valid <= '0;
		end else begin
			if (retire_write) begin
				regs[rd_index] <= rd;
			end
			if (retire_clear) begin
				tags[rd_index]      <= '0;
				tag_valid[rd_index] <= 1'b0;
			end
			// rename comes last so it overrides a clear to the same register
			if (rename_write) begin
				tags[rename_index]      <= rename_tag;
				tag_valid[rename_index] <= 1'b1;
			end
		end
	end

	// reads see the state from before this cycle's rename and retire
	assign rs1               = regs[rs1_index];
	assign rs1_rob_tag       = tags[rs1_index];
	assign rs1_rob_tag_valid = tag_valid[rs1_index];

	assign rs2               = regs[rs2_index];
	assign rs2_rob_tag       = tags[rs2_index];
	assign rs2_rob_tag_valid = tag_valid[rs2_index];

endmodule

//--- design/ooo_pkg.sv
`include "ooo_consts.svh"

package ooo_pkg;

	// one data word as it sits in a register or a ROB entry
	typedef logic [`XLEN-1:0] word_t;

	// architectural register index
	// five bits cover the 32 registers
	typedef logic [4:0] reg_index_t;

	// ROB entry index
	// doubles as the producer tag held in the register file
	typedef logic [`ROB_TAG_WIDTH-1:0] rob_tag_t;

endpackage

//--- include/ooo_consts.svh
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// width of one data word
`define XLEN 32

// architectural registers
// register 0 always reads as zero
`define NUM_REGS 32

// in-flight instructions the ROB can hold
// the upstream also starts with this many credits
`define ROB_DEPTH 8

// bits needed to name one ROB entry
`define ROB_TAG_WIDTH 3

`endif
